// ==== hdl/wfg_stim_sine_pkg.sv ====
/* sine stimulus shared definitions */
package wfg_stim_sine_pkg;

    // bus and datapath widths
    localparam int BUSW = 32;
    localparam int PHASE_W = 16;
    localparam int SINE_W = 16;
    localparam int GAIN_W = 16;
    localparam int GAIN_FRAC = 14;
    localparam int OUT_W = 18;

    // cordic geometry, angle lsb is one 2^20th of a turn
    localparam int CORDIC_ITER = 16;
    localparam int CORDIC_ITER_W = $clog2(CORDIC_ITER);
    localparam int CORDIC_GUARD = 4;
    localparam int CORDIC_XY_W = SINE_W + CORDIC_GUARD + 1;
    localparam int CORDIC_Z_W = PHASE_W + CORDIC_GUARD;

    // 32767 * K * 2^guard, with K the cordic gain of about 0.60725
    localparam logic signed [CORDIC_XY_W-1:0] CORDIC_X_INIT = 318366;
    localparam logic signed [CORDIC_XY_W-1:0] CORDIC_RND = 1 <<< (CORDIC_GUARD - 1);

    // signed limits
    localparam int SINE_MAX = 2 ** (SINE_W - 1) - 1;
    localparam int OUT_MAX = 2 ** (OUT_W - 1) - 1;
    localparam int OUT_MIN = -(2 ** (OUT_W - 1));

    typedef logic [PHASE_W-1:0] phase_t;
    typedef logic signed [SINE_W-1:0] sine_t;
    typedef logic [GAIN_W-1:0] gain_t;
    typedef logic signed [OUT_W-1:0] offset_t;
    typedef logic signed [OUT_W-1:0] stim_data_t;

    // register map
    localparam logic [BUSW-1:0] REG_CTRL_ADR = 32'h0;
    localparam logic [BUSW-1:0] REG_INC_ADR = 32'h4;
    localparam logic [BUSW-1:0] REG_GAIN_ADR = 32'h8;
    localparam logic [BUSW-1:0] REG_OFFSET_ADR = 32'hC;

    localparam phase_t INC_RESET = 16'h1000;
    // unity gain in unsigned q2.14
    localparam gain_t GAIN_RESET = 16'h4000;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        OUTPUT
    } ctrl_state_e;

endpackage

// ==== hdl/wfg_stim_sine_wishbone_reg.sv ====
/* sine stimulus wishbone registers */
`timescale 1ns/1ns

module wfg_stim_sine_wishbone_reg (
    // wishbone slave
    input  logic                                    wb_clk_i,
    input  logic                                    wb_rst_i,
    input  logic                                    wbs_stb_i,
    input  logic                                    wbs_cyc_i,
    input  logic                                    wbs_we_i,
    input  logic [wfg_stim_sine_pkg::BUSW/8-1:0]    wbs_sel_i,
    input  logic [wfg_stim_sine_pkg::BUSW-1:0]      wbs_dat_i,
    input  logic [wfg_stim_sine_pkg::BUSW-1:0]      wbs_adr_i,
    output logic                                    wbs_ack_o,
    output logic [wfg_stim_sine_pkg::BUSW-1:0]      wbs_dat_o,

    // register fields
    output logic                                    ctrl_en_q_o,
    output wfg_stim_sine_pkg::phase_t               inc_val_q_o,
    output wfg_stim_sine_pkg::gain_t                gain_val_q_o,
    output wfg_stim_sine_pkg::offset_t              offset_val_q_o
);

    import wfg_stim_sine_pkg::*;

    // field flops
    logic       ctrl_en_ff;
    phase_t     inc_val_ff;
    gain_t      gain_val_ff;
    offset_t    offset_val_ff;

    // qualified bus cycles
    logic       bus_stb;
    logic       bus_wr;

    assign bus_stb = wbs_stb_i && wbs_cyc_i;
    assign bus_wr = bus_stb && wbs_we_i;

    // byte lanes are not decoded
    // every write replaces the whole field
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ctrl_en_ff    <= 1'b0;
            inc_val_ff    <= INC_RESET;
            gain_val_ff   <= GAIN_RESET;
            offset_val_ff <= '0;
        end else if (bus_wr) begin
            // only the field width is kept
            case (wbs_adr_i)
                REG_CTRL_ADR: begin
                    ctrl_en_ff <= wbs_dat_i[0];
                end
                REG_INC_ADR: begin
                    inc_val_ff <= wbs_dat_i[PHASE_W-1:0];
                end
                REG_GAIN_ADR: begin
                    gain_val_ff <= wbs_dat_i[GAIN_W-1:0];
                end
                REG_OFFSET_ADR: begin
                    offset_val_ff <= wbs_dat_i[OUT_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // read mux, straight from the address
    // upper bits zero, offset is not sign extended
    always_comb begin
        wbs_dat_o = '0;
        case (wbs_adr_i)
            REG_CTRL_ADR: begin
                wbs_dat_o[0] = ctrl_en_ff;
            end
            REG_INC_ADR: begin
                wbs_dat_o[PHASE_W-1:0] = inc_val_ff;
            end
            REG_GAIN_ADR: begin
                wbs_dat_o[GAIN_W-1:0] = gain_val_ff;
            end
            REG_OFFSET_ADR: begin
                wbs_dat_o[OUT_W-1:0] = offset_val_ff;
            end
            default: begin
                // unmapped reads as zero
                wbs_dat_o = '0;
            end
        endcase
    end

    // ack one cycle after each strobed cycle
    // master drops stb once it sees ack
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o <= 1'b0;
        end else begin
            wbs_ack_o <= bus_stb;
        end
    end

    // field outputs
    assign ctrl_en_q_o    = ctrl_en_ff;
    assign inc_val_q_o    = inc_val_ff;
    assign gain_val_q_o   = gain_val_ff;
    assign offset_val_q_o = offset_val_ff;

endmodule

// ==== hdl/wfg_stim_sine_ctrl.sv ====
/* sine stimulus sequencer */
`timescale 1ns/1ns

module wfg_stim_sine_ctrl (
    input  logic                        wb_clk_i,
    input  logic                        wb_rst_i,
    input  logic                        ctrl_en_i,
    input  wfg_stim_sine_pkg::phase_t   inc_val_i,
    input  logic                        cordic_done_i,
    input  logic                        wfg_stim_ready_i,
    output wfg_stim_sine_pkg::phase_t   phase_o,
    output logic                        cordic_start_o,
    output logic                        wfg_stim_valid_o
);

    import wfg_stim_sine_pkg::*;

    ctrl_state_e state_q;
    phase_t      phase_q;
    logic        start_q;
    logic        valid_q;

    // hand-off on the stream
    logic        xfer;

    assign xfer = valid_q && wfg_stim_ready_i;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q <= IDLE;
            phase_q <= '0;
            start_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            // start is a single cycle pulse
            start_q <= 1'b0;
            if (!ctrl_en_i) begin
                // disabled, back to phase zero
                state_q <= IDLE;
                phase_q <= '0;
                valid_q <= 1'b0;
            end else begin
                case (state_q)
                    IDLE: begin
                        // first sample at the current phase
                        state_q <= CALC;
                        start_q <= 1'b1;
                    end
                    CALC: begin
                        // a done seen with a fresh start belongs to an aborted run
                        if (cordic_done_i && !start_q) begin
                            state_q <= OUTPUT;
                            valid_q <= 1'b1;
                        end
                    end
                    OUTPUT: begin
                        // hold until the sink takes it
                        if (xfer) begin
                            valid_q <= 1'b0;
                            phase_q <= phase_q + inc_val_i;
                            start_q <= 1'b1;
                            state_q <= CALC;
                        end
                    end
                    default: begin
                        state_q <= IDLE;
                    end
                endcase
            end
        end
    end

    assign phase_o = phase_q;
    assign cordic_start_o = start_q;
    assign wfg_stim_valid_o = valid_q;

endmodule

// ==== hdl/wfg_stim_sine_cordic.sv ====
/* iterative sine cordic */
`timescale 1ns/1ns

module wfg_stim_sine_cordic (
    input  logic                        wb_clk_i,
    input  logic                        wb_rst_i,
    input  logic                        start_i,
    input  wfg_stim_sine_pkg::phase_t   phase_i,
    output wfg_stim_sine_pkg::sine_t    sine_o,
    output logic                        done_o
);

    import wfg_stim_sine_pkg::*;

    // arctan(2^-i) in 2^20ths of a turn
    function automatic logic signed [CORDIC_Z_W-1:0] atan_lut(
        input logic [CORDIC_ITER_W-1:0] idx
    );
        case (idx)
            0:  return 131072;
            1:  return 77376;
            2:  return 40884;
            3:  return 20753;
            4:  return 10417;
            5:  return 5213;
            6:  return 2607;
            7:  return 1304;
            8:  return 652;
            9:  return 326;
            10: return 163;
            11: return 81;
            12: return 41;
            13: return 20;
            14: return 10;
            15: return 5;
        endcase
    endfunction

    // control
    logic                           busy_q;
    logic                           done_q;
    logic [CORDIC_ITER_W-1:0]       iter_q;

    // datapath
    logic signed [CORDIC_XY_W-1:0]  x_q;
    logic signed [CORDIC_XY_W-1:0]  y_q;
    logic signed [CORDIC_Z_W-1:0]   z_q;
    logic                           neg_q;
    logic signed [CORDIC_XY_W-1:0]  x_nxt;
    logic signed [CORDIC_XY_W-1:0]  y_nxt;
    logic signed [CORDIC_Z_W-1:0]   z_nxt;

    // quadrant fold
    phase_t                         half;
    phase_t                         fold;

    // output stage
    logic signed [CORDIC_XY_W-1:0]  y_rnd;
    sine_t                          y_sat;

    // lower half turn, then mirror about a quarter turn
    assign half = {1'b0, phase_i[PHASE_W-2:0]};
    assign fold = (half > phase_t'(2 ** (PHASE_W - 2))) ?
                  phase_t'(2 ** (PHASE_W - 1)) - half : half;

    // one rotation step, direction from the residual angle
    always_comb begin
        if (!z_q[CORDIC_Z_W-1]) begin
            x_nxt = x_q - (y_q >>> iter_q);
            y_nxt = y_q + (x_q >>> iter_q);
            z_nxt = z_q - atan_lut(iter_q);
        end else begin
            x_nxt = x_q + (y_q >>> iter_q);
            y_nxt = y_q - (x_q >>> iter_q);
            z_nxt = z_q + atan_lut(iter_q);
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            iter_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                // a new start aborts any run in progress
                busy_q <= 1'b1;
                iter_q <= '0;
            end else if (busy_q) begin
                iter_q <= iter_q + 1'b1;
                if (iter_q == CORDIC_ITER_W'(CORDIC_ITER - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // vector registers
    always_ff @(posedge wb_clk_i) begin
        if (start_i) begin
            x_q   <= CORDIC_X_INIT;
            y_q   <= '0;
            z_q   <= {fold, {CORDIC_GUARD{1'b0}}};
            // second half turn gives a negative sine
            neg_q <= phase_i[PHASE_W-1];
        end else if (busy_q) begin
            x_q <= x_nxt;
            y_q <= y_nxt;
            z_q <= z_nxt;
        end
    end

    // drop guard bits with rounding, clamp to full scale
    always_comb begin
        y_rnd = (y_q + CORDIC_RND) >>> CORDIC_GUARD;
        if (y_rnd > SINE_MAX) begin
            y_sat = sine_t'(SINE_MAX);
        end else if (y_rnd < -SINE_MAX) begin
            y_sat = sine_t'(-SINE_MAX);
        end else begin
            y_sat = sine_t'(y_rnd);
        end
    end

    assign sine_o = neg_q ? -y_sat : y_sat;
    assign done_o = done_q;

endmodule

// ==== hdl/wfg_stim_sine_scale.sv ====
/* sine gain and offset stage */
`timescale 1ns/1ns

module wfg_stim_sine_scale (
    input  logic                            wb_clk_i,
    input  logic                            wb_rst_i,
    input  logic                            load_i,
    input  wfg_stim_sine_pkg::sine_t        sine_i,
    input  wfg_stim_sine_pkg::gain_t        gain_i,
    input  wfg_stim_sine_pkg::offset_t      offset_i,
    output wfg_stim_sine_pkg::stim_data_t   data_o
);

    import wfg_stim_sine_pkg::*;

    // full product of signed sine and unsigned gain
    logic signed [SINE_W+GAIN_W:0]  prod;
    // two spare bits above the output range
    logic signed [OUT_W+1:0]        scaled;
    logic signed [OUT_W+1:0]        sum;
    stim_data_t                     sat;
    stim_data_t                     data_q;

    always_comb begin
        // gain zero-extended so it multiplies as signed
        prod = sine_i * $signed({1'b0, gain_i});
        // back from q2.14
        scaled = (OUT_W + 2)'(prod >>> GAIN_FRAC);
        sum = scaled + offset_i;
        // clip into the 18-bit signed range
        if (sum > OUT_MAX) begin
            sat = stim_data_t'(OUT_MAX);
        end else if (sum < OUT_MIN) begin
            sat = stim_data_t'(OUT_MIN);
        end else begin
            sat = stim_data_t'(sum);
        end
    end

    // sample register, loaded once per cordic result
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            data_q <= '0;
        end else if (load_i) begin
            data_q <= sat;
        end
    end

    assign data_o = data_q;

endmodule

// ==== hdl/wfg_stim_sine_top.sv ====
/* sine stimulus generator */
`timescale 1ns/1ns

module wfg_stim_sine_top (
    input  logic                                    wb_clk_i,
    input  logic                                    wb_rst_i,

    // wishbone slave
    input  logic                                    wbs_stb_i,
    input  logic                                    wbs_cyc_i,
    input  logic                                    wbs_we_i,
    input  logic [wfg_stim_sine_pkg::BUSW/8-1:0]    wbs_sel_i,
    input  logic [wfg_stim_sine_pkg::BUSW-1:0]      wbs_dat_i,
    input  logic [wfg_stim_sine_pkg::BUSW-1:0]      wbs_adr_i,
    output logic                                    wbs_ack_o,
    output logic [wfg_stim_sine_pkg::BUSW-1:0]      wbs_dat_o,

    // stimulus stream
    input  logic                                    wfg_stim_ready_i,
    output logic                                    wfg_stim_valid_o,
    output wfg_stim_sine_pkg::stim_data_t           wfg_stim_data_o
);

    import wfg_stim_sine_pkg::*;

    // register fields
    logic       ctrl_en;
    phase_t     inc_val;
    gain_t      gain_val;
    offset_t    offset_val;

    // sequencer to cordic
    phase_t     phase;
    logic       cordic_start;

    // cordic to scaler and sequencer
    sine_t      sine;
    logic       cordic_done;

    wfg_stim_sine_wishbone_reg u_regs (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .wbs_stb_i      (wbs_stb_i),
        .wbs_cyc_i      (wbs_cyc_i),
        .wbs_we_i       (wbs_we_i),
        .wbs_sel_i      (wbs_sel_i),
        .wbs_dat_i      (wbs_dat_i),
        .wbs_adr_i      (wbs_adr_i),
        .wbs_ack_o      (wbs_ack_o),
        .wbs_dat_o      (wbs_dat_o),
        .ctrl_en_q_o    (ctrl_en),
        .inc_val_q_o    (inc_val),
        .gain_val_q_o   (gain_val),
        .offset_val_q_o (offset_val)
    );

    wfg_stim_sine_ctrl u_ctrl (
        .wb_clk_i         (wb_clk_i),
        .wb_rst_i         (wb_rst_i),
        .ctrl_en_i        (ctrl_en),
        .inc_val_i        (inc_val),
        .cordic_done_i    (cordic_done),
        .wfg_stim_ready_i (wfg_stim_ready_i),
        .phase_o          (phase),
        .cordic_start_o   (cordic_start),
        .wfg_stim_valid_o (wfg_stim_valid_o)
    );

    wfg_stim_sine_cordic u_cordic (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .start_i  (cordic_start),
        .phase_i  (phase),
        .sine_o   (sine),
        .done_o   (cordic_done)
    );

    // sample lands one cycle after done, with valid
    wfg_stim_sine_scale u_scale (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .load_i   (cordic_done),
        .sine_i   (sine),
        .gain_i   (gain_val),
        .offset_i (offset_val),
        .data_o   (wfg_stim_data_o)
    );

endmodule

// ==== test/wfg_stim_sine_properties.sv ====
/* stream and bus handshake properties */
`timescale 1ns/1ns

module wfg_stim_sine_properties (
    input logic                             wb_clk_i,
    input logic                             wb_rst_i,
    input logic                             wbs_stb_i,
    input logic                             wbs_cyc_i,
    input logic                             wbs_ack_o,
    input logic                             wfg_stim_ready_i,
    input logic                             wfg_stim_valid_o,
    input wfg_stim_sine_pkg::stim_data_t    wfg_stim_data_o,
    input logic                             ctrl_en
);

    // failures seen so far
    int error_count = 0;

    // ack is the strobe, one edge later
    ack_follows_strobe: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        1'b1 |=> (wbs_ack_o == $past(wbs_stb_i && wbs_cyc_i))
    ) else begin
        error_count++;
        $error("wishbone ack does not follow stb and cyc by one cycle");
    end

    // stalled sample stays put while enabled
    stream_held: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        (wfg_stim_valid_o && !wfg_stim_ready_i && ctrl_en) |=>
            (wfg_stim_valid_o && $stable(wfg_stim_data_o))
    ) else begin
        error_count++;
        $error("stream sample changed or valid dropped under back-pressure");
    end

    valid_low_in_reset: assert property (
        @(posedge wb_clk_i) wb_rst_i |=> !wfg_stim_valid_o
    ) else begin
        error_count++;
        $error("stream valid high during reset");
    end

    valid_low_when_off: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        !ctrl_en |=> !wfg_stim_valid_o
    ) else begin
        error_count++;
        $error("stream valid high while the enable is clear");
    end

endmodule

bind wfg_stim_sine_top wfg_stim_sine_properties u_props (
    .wb_clk_i         (wb_clk_i),
    .wb_rst_i         (wb_rst_i),
    .wbs_stb_i        (wbs_stb_i),
    .wbs_cyc_i        (wbs_cyc_i),
    .wbs_ack_o        (wbs_ack_o),
    .wfg_stim_ready_i (wfg_stim_ready_i),
    .wfg_stim_valid_o (wfg_stim_valid_o),
    .wfg_stim_data_o  (wfg_stim_data_o),
    .ctrl_en          (ctrl_en)
);

// ==== test/wfg_stim_sine_tb.sv ====
/* sine stimulus testbench */
`timescale 1ns/1ns

module wfg_stim_sine_tb;

    import wfg_stim_sine_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 5;
    localparam int RESET_CYCLES = 10;
    localparam int ACK_LIMIT = 8;
    localparam real PI = 3.14159265358979;
    localparam string PATTERN_FILE = "test/wfg_stim_sine_patterns.txt";

    // dut ports
    logic                   wb_clk_i;
    logic                   wb_rst_i;
    logic                   wbs_stb_i;
    logic                   wbs_cyc_i;
    logic                   wbs_we_i;
    logic [BUSW/8-1:0]      wbs_sel_i;
    logic [BUSW-1:0]        wbs_dat_i;
    logic [BUSW-1:0]        wbs_adr_i;
    logic                   wbs_ack_o;
    logic [BUSW-1:0]        wbs_dat_o;
    logic                   wfg_stim_ready_i;
    logic                   wfg_stim_valid_o;
    stim_data_t             wfg_stim_data_o;

    // pattern lines, opcode and two hex fields
    byte                    op_q[$];
    logic [BUSW-1:0]        arg_a_q[$];
    logic [BUSW-1:0]        arg_b_q[$];

    // reference model state
    phase_t                 model_phase;
    phase_t                 model_inc;
    gain_t                  model_gain;
    offset_t                model_offset;
    int                     sample_count;
    int                     seed;
    int                     watchdog_cycles = 0;

    wfg_stim_sine_top dut (
        .wb_clk_i         (wb_clk_i),
        .wb_rst_i         (wb_rst_i),
        .wbs_stb_i        (wbs_stb_i),
        .wbs_cyc_i        (wbs_cyc_i),
        .wbs_we_i         (wbs_we_i),
        .wbs_sel_i        (wbs_sel_i),
        .wbs_dat_i        (wbs_dat_i),
        .wbs_adr_i        (wbs_adr_i),
        .wbs_ack_o        (wbs_ack_o),
        .wbs_dat_o        (wbs_dat_o),
        .wfg_stim_ready_i (wfg_stim_ready_i),
        .wfg_stim_valid_o (wfg_stim_valid_o),
        .wfg_stim_data_o  (wfg_stim_data_o)
    );

    always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // budget is known once the patterns are loaded
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge wb_clk_i);
        $display("timeout, the patterns did not finish within %0d cycles", watchdog_cycles);
        abort_run();
    end

    // bound assertions count their failures
    always @(dut.u_props.error_count) begin
        if (dut.u_props.error_count != 0) begin
            $display("a bound handshake assertion failed");
            abort_run();
        end
    end

    task automatic load_patterns();
        int fd;
        int fields;
        string line;
        byte op;
        logic [BUSW-1:0] a;
        logic [BUSW-1:0] b;
        real budget;
        fd = $fopen(PATTERN_FILE, "r");
        assert (fd != 0) else begin
            $display("cannot open the pattern file %s", PATTERN_FILE);
            abort_run();
        end
        budget = 0.0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // blank lines and comments carry no command
            if (line.len() > 2 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%c %h %h", op, a, b);
                assert (fields == 3) else begin
                    $display("malformed pattern line: %s", line);
                    abort_run();
                end
                op_q.push_back(op);
                arg_a_q.push_back(a);
                arg_b_q.push_back(b);
                budget += 200.0;
                if (op == "S") begin
                    assert (b < 100) else begin
                        $display("back-pressure of %0d percent would never finish", b);
                        abort_run();
                    end
                    // slower sink stretches every sample
                    budget += 40.0 * a * 100.0 / (100 - b);
                end
            end
        end
        $fclose(fd);
        watchdog_cycles = RESET_CYCLES + $rtoi(budget);
    endtask

    // single classic cycle, entered and left just after an edge
    task automatic bus_cycle(input logic we, input logic [BUSW-1:0] adr,
                             input logic [BUSW-1:0] wdat, output logic [BUSW-1:0] rdat);
        int waited;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_sel_i = '1;
        wbs_adr_i = adr;
        wbs_dat_i = wdat;
        waited = 0;
        do begin
            @(posedge wb_clk_i);
            #DRIVE_DELAY;
            waited++;
        end while (!wbs_ack_o && waited < ACK_LIMIT);
        assert (wbs_ack_o) else begin
            $display("no acknowledge from the register block at address %h", adr);
            abort_run();
        end
        // read data is stable while ack is high
        rdat = wbs_dat_o;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    task automatic check_valid_low();
        repeat (CORDIC_ITER + 4) begin
            @(posedge wb_clk_i);
            #DRIVE_DELAY;
            assert (!wfg_stim_valid_o) else begin
                $display("FAILED wfg_stim_valid_o after disable: got %h expected %h",
                         wfg_stim_valid_o, 1'b0);
                abort_run();
            end
        end
    endtask

    task automatic write_reg(input logic [BUSW-1:0] adr, input logic [BUSW-1:0] dat);
        logic [BUSW-1:0] rdat;
        bus_cycle(1'b1, adr, dat, rdat);
        // model keeps only the field widths
        case (adr)
            REG_CTRL_ADR: begin
                if (!dat[0]) begin
                    // sequencer restarts from phase zero
                    model_phase = '0;
                    check_valid_low();
                end
            end
            REG_INC_ADR: begin
                model_inc = dat[PHASE_W-1:0];
            end
            REG_GAIN_ADR: begin
                model_gain = dat[GAIN_W-1:0];
            end
            REG_OFFSET_ADR: begin
                model_offset = dat[OUT_W-1:0];
            end
            default: begin
            end
        endcase
    endtask

    task automatic read_check(input logic [BUSW-1:0] adr, input logic [BUSW-1:0] expected);
        logic [BUSW-1:0] rdat;
        bus_cycle(1'b0, adr, '0, rdat);
        assert (rdat == expected) else begin
            $display("FAILED wbs_dat_o at address %h: got %h expected %h", adr, rdat, expected);
            abort_run();
        end
    endtask

    task automatic check_sample(input stim_data_t data);
        real ideal;
        real tol;
        real clipped;
        int got;
        int expected;
        // rounded full-scale sine, then gain in q2.14 and offset
        ideal = $floor(32767.0 * $sin(2.0 * PI * model_phase / 65536.0) + 0.5);
        ideal = ideal * model_gain / 16384.0 + model_offset;
        tol = 4.0 * model_gain / 16384.0 + 1.0;
        got = data;
        if (ideal > OUT_MAX) begin
            clipped = OUT_MAX;
        end else if (ideal < OUT_MIN) begin
            clipped = OUT_MIN;
        end else begin
            clipped = ideal;
        end
        expected = $rtoi($floor(clipped + 0.5));
        // well past a limit the clip must be exact
        if (ideal > OUT_MAX + tol || ideal < OUT_MIN - tol) begin
            tol = 0.0;
        end
        assert ((got - clipped <= tol) && (clipped - got <= tol)) else begin
            $display("FAILED wfg_stim_data_o sample %0d phase %h: got %h expected %h",
                     sample_count, model_phase, data, stim_data_t'(expected));
            abort_run();
        end
    endtask

    task automatic collect_samples(input logic [BUSW-1:0] count, input logic [BUSW-1:0] pct);
        int taken;
        int r;
        taken = 0;
        while (taken < count) begin
            r = $random(seed);
            // ready low for pct percent of the cycles
            wfg_stim_ready_i = ((r & 32'h7fff_ffff) % 100) >= pct;
            // both high now means a hand-off at the next edge
            if (wfg_stim_valid_o && wfg_stim_ready_i) begin
                check_sample(wfg_stim_data_o);
                model_phase = model_phase + model_inc;
                sample_count++;
                taken++;
            end
            @(posedge wb_clk_i);
            #DRIVE_DELAY;
        end
        // park the sink, the next sample waits in the dut
        wfg_stim_ready_i = 1'b0;
    endtask

    initial begin
        wb_clk_i = 1'b0;
        wb_rst_i = 1'b1;
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_we_i = 1'b0;
        wbs_sel_i = '0;
        wbs_dat_i = '0;
        wbs_adr_i = '0;
        wfg_stim_ready_i = 1'b0;
        seed = 32'h135ec01b;
        model_phase = '0;
        model_inc = INC_RESET;
        model_gain = GAIN_RESET;
        model_offset = '0;
        sample_count = 0;
        load_patterns();
        repeat (RESET_CYCLES) @(posedge wb_clk_i);
        #DRIVE_DELAY;
        wb_rst_i = 1'b0;
        foreach (op_q[i]) begin
            case (op_q[i])
                "W": write_reg(arg_a_q[i], arg_b_q[i]);
                "R": read_check(arg_a_q[i], arg_b_q[i]);
                "S": collect_samples(arg_a_q[i], arg_b_q[i]);
                default: begin
                    $display("unknown opcode %c on pattern line %0d", op_q[i], i);
                    abort_run();
                end
            endcase
        end
        // a few more edges for the bound checks
        repeat (4) @(posedge wb_clk_i);
        if (dut.u_props.error_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("%0d bound assertion failures", dut.u_props.error_count);
            abort_run();
        end
    end

endmodule

// ==== test/wfg_stim_sine_patterns.txt ====
# op adr data : W writes data to adr, R reads adr and expects data
# S count pct : S takes count samples, ready low pct percent of cycles, all fields hex
R 00000000 00000000
R 00000004 00001000
R 00000008 00004000
R 0000000c 00000000
W 00000004 abcd1234
R 00000004 00001234
W 00000008 ffff5a5a
R 00000008 00005a5a
W 0000000c ffffffff
R 0000000c 0003ffff
W 00000000 fffffffe
R 00000000 00000000
W 00000010 12345678
R 00000010 00000000
W 00000004 00001000
W 00000008 00004000
W 0000000c 00000000
W 00000000 00000001
R 00000000 00000001
S 00000040 00000000
W 00000000 00000000
W 00000008 0000c000
W 0000000c 00010000
W 00000000 00000001
S 00000020 00000000
W 00000000 00000000
W 0000000c 00030000
W 00000000 00000001
S 00000020 00000000
W 00000000 00000000
W 00000008 00004000
W 0000000c 00000000
W 00000004 00000b3d
W 00000000 00000001
S 00000040 00000032
W 00000000 00000000
W 00000000 00000001
S 00000010 00000019

// ==== compile.f ====
hdl/wfg_stim_sine_pkg.sv
hdl/wfg_stim_sine_wishbone_reg.sv
hdl/wfg_stim_sine_ctrl.sv
hdl/wfg_stim_sine_cordic.sv
hdl/wfg_stim_sine_scale.sv
hdl/wfg_stim_sine_top.sv
test/wfg_stim_sine_properties.sv
test/wfg_stim_sine_tb.sv

// ==== Bender.yml ====
package:
  name: wfg_stim_sine

dependencies: {}

sources:
  # design, package first
  - files:
      - hdl/wfg_stim_sine_pkg.sv
      - hdl/wfg_stim_sine_wishbone_reg.sv
      - hdl/wfg_stim_sine_ctrl.sv
      - hdl/wfg_stim_sine_cordic.sv
      - hdl/wfg_stim_sine_scale.sv
      - hdl/wfg_stim_sine_top.sv
  # simulation only
  - target: test
    files:
      - test/wfg_stim_sine_properties.sv
      - test/wfg_stim_sine_tb.sv
